// File: cpu_pkg.sv
package cpu_pkg;

        localparam int data_w     = 16;
        localparam int reg_addr_w = 3;
        localparam int mem_addr_w = 6;

        // One instruction frame runs from count 0 up to frame_last.
        localparam int frame_last = 20;
        localparam int ph_fetch   = 1;
        localparam int ph_exec    = 7;
        localparam int ph_mem     = 14;
        localparam int ph_wb      = 20;

        localparam int md_steps   = 16;

        typedef enum logic [3:0] {
                op_add,
                op_sub,
                op_and,
                op_or,
                op_xor,
                op_addi,
                op_mul,
                op_div,
                op_ld,
                op_st
        } opcode_e;

        // Register form, used by the ALU, mul/div and store ops.
        typedef struct packed {
                opcode_e               opcode;
                logic [reg_addr_w-1:0] rd;
                logic [reg_addr_w-1:0] rs1;
                logic [reg_addr_w-1:0] rs2;
                logic [2:0]            pad;
        } instr_r_t;

        // Immediate form, used by addi, load and store.
        typedef struct packed {
                opcode_e               opcode;
                logic [reg_addr_w-1:0] rd;
                logic [reg_addr_w-1:0] rs1;
                logic signed [5:0]     imm;
        } instr_i_t;

        typedef union packed {
                instr_r_t r;
                instr_i_t i;
        } instr_u;

        typedef struct packed {
                logic [reg_addr_w-1:0] rd;
                logic [data_w-1:0]     data;
        } wb_result_t;

        typedef struct packed {
                logic fetch;
                logic exec;
                logic mem;
                logic wb;
        } phase_t;

endpackage

// File: phase_gen.sv
module phase_gen (
        input  logic            clk_100M,
        input  logic            rst_n,
        input  logic            md_busy,
        output cpu_pkg::phase_t phase
);
        import cpu_pkg::*;

        logic [$clog2(frame_last+1)-1:0] count;

        // The frame stands still while the mul/div unit iterates, so the
        // later steps of the frame wait for its result.
        always_ff @(posedge clk_100M or negedge rst_n) begin
                if (!rst_n) begin
                        count <= '0;
                end else if (!md_busy) begin
                        if (count == frame_last)
                                count <= '0;
                        else
                                count <= count + 1'b1;
                end
        end

        // Each strobe lasts the single cycle in which the count hits its slot.
        assign phase.fetch = (count == ph_fetch);
        assign phase.exec  = (count == ph_exec);
        assign phase.mem   = (count == ph_mem);
        assign phase.wb    = (count == ph_wb);

        a_one_strobe: assert property (
                @(posedge clk_100M) disable iff (!rst_n)
                $onehot0(phase)
        );

        a_frozen: assert property (
                @(posedge clk_100M) disable iff (!rst_n)
                md_busy |=> (count == $past(count))
        );

endmodule

// File: instr_fetch.sv
module instr_fetch (
        input  logic            clk_100M,
        input  logic            rst_n,
        input  logic            instr_valid,
        output logic            instr_ready,
        input  cpu_pkg::instr_u instr,
        input  cpu_pkg::phase_t phase,
        output cpu_pkg::instr_u cur_instr,
        output logic            cur_valid
);
        import cpu_pkg::*;

        instr_u buf_instr;
        logic   buf_full;
        logic   take;

        assign instr_ready = !buf_full;
        assign take        = instr_valid && instr_ready;

        // A transfer only happens into an empty buffer, so it never collides
        // with the buffer being drained at the fetch strobe.
        always_ff @(posedge clk_100M or negedge rst_n) begin
                if (!rst_n) begin
                        buf_full  <= 1'b0;
                        cur_valid <= 1'b0;
                end else begin
                        if (take)
                                buf_full <= 1'b1;
                        else if (phase.fetch)
                                buf_full <= 1'b0;
                        if (phase.fetch)
                                cur_valid <= buf_full;
                end
        end

        always_ff @(posedge clk_100M) begin
                if (take)
                        buf_instr <= instr;
                if (phase.fetch)
                        cur_instr <= buf_instr;
        end

endmodule

// File: reg_file.sv
module reg_file (
        input  logic                           clk_100M,
        input  logic                           rst_n,
        input  logic [cpu_pkg::reg_addr_w-1:0] rs1,
        input  logic [cpu_pkg::reg_addr_w-1:0] rs2,
        output logic [cpu_pkg::data_w-1:0]     rs1_data,
        output logic [cpu_pkg::data_w-1:0]     rs2_data,
        input  logic                           we,
        input  cpu_pkg::wb_result_t            wb_result
);
        import cpu_pkg::*;

        logic [data_w-1:0] regs [2**reg_addr_w];

        always_ff @(posedge clk_100M or negedge rst_n) begin
                if (!rst_n) begin
                        for (int k = 0; k < 2**reg_addr_w; k++)
                                regs[k] <= '0;
                end else if (we) begin
                        regs[wb_result.rd] <= wb_result.data;
                end
        end

        // Reads see the value written at the previous frame's write-back.
        assign rs1_data = regs[rs1];
        assign rs2_data = regs[rs2];

endmodule

// File: alu.sv
module alu (
        input  cpu_pkg::instr_u            cur_instr,
        input  logic [cpu_pkg::data_w-1:0] a,
        input  logic [cpu_pkg::data_w-1:0] b,
        output logic [cpu_pkg::data_w-1:0] y
);
        import cpu_pkg::*;

        logic [data_w-1:0] imm_ext;

        // Immediate view of the word, sign-extended to the data width.
        assign imm_ext = {{(data_w-6){cur_instr.i.imm[5]}}, cur_instr.i.imm};

        always_comb begin
                case (cur_instr.r.opcode)
                        op_sub:
                                y = a - b;
                        op_and:
                                y = a & b;
                        op_or:
                                y = a | b;
                        op_xor:
                                y = a ^ b;
                        // Addi and the memory ops share the address adder.
                        op_addi, op_ld, op_st:
                                y = a + imm_ext;
                        default:
                                y = a + b;
                endcase
        end

endmodule

// File: mul_div_unit.sv
module mul_div_unit (
        input  logic                       clk_100M,
        input  logic                       rst_n,
        input  logic                       start,
        input  logic                       is_div,
        input  logic [cpu_pkg::data_w-1:0] a,
        input  logic [cpu_pkg::data_w-1:0] b,
        output logic                       md_busy,
        output logic [cpu_pkg::data_w-1:0] md_result
);
        import cpu_pkg::*;

        logic [$clog2(md_steps)-1:0] step;
        logic                        div_mode;
        logic [data_w:0]             acc;
        logic [data_w-1:0]           opq;
        logic [data_w-1:0]           opb;
        logic [data_w:0]             rem_shift;
        logic [data_w:0]             diff;

        // Restoring step: shift the next dividend bit into the remainder and
        // try the subtraction. A zero divisor never borrows, so the quotient
        // comes out as all ones.
        assign rem_shift = {acc[data_w-1:0], opq[data_w-1]};
        assign diff      = rem_shift - {1'b0, opb};

        always_ff @(posedge clk_100M or negedge rst_n) begin
                if (!rst_n) begin
                        md_busy <= 1'b0;
                        step    <= '0;
                end else if (start) begin
                        md_busy <= 1'b1;
                        step    <= '0;
                end else if (md_busy) begin
                        step <= step + 1'b1;
                        if (step == md_steps - 1)
                                md_busy <= 1'b0;
                end
        end

        always_ff @(posedge clk_100M) begin
                if (start) begin
                        div_mode <= is_div;
                        acc      <= '0;
                        opq      <= a;
                        opb      <= b;
                end else if (md_busy) begin
                        if (div_mode) begin
                                acc <= diff[data_w] ? rem_shift : diff;
                                opq <= {opq[data_w-2:0], !diff[data_w]};
                        end else begin
                                if (opq[0])
                                        acc <= {1'b0, acc[data_w-1:0] + opb};
                                opq <= opq >> 1;
                                opb <= opb << 1;
                        end
                end
        end

        // The quotient ends up in opq, the low product bits in acc.
        assign md_result = div_mode ? opq : acc[data_w-1:0];

        a_no_restart: assert property (
                @(posedge clk_100M) disable iff (!rst_n)
                start |-> !md_busy
        );

endmodule

// File: data_ram.sv
module data_ram (
        input  logic                           clk_100M,
        input  logic                           rst_n,
        input  cpu_pkg::phase_t                phase,
        input  logic                           we,
        input  logic                           re,
        input  logic [cpu_pkg::mem_addr_w-1:0] addr,
        input  logic [cpu_pkg::data_w-1:0]     wdata,
        output logic [cpu_pkg::data_w-1:0]     rdata
);
        import cpu_pkg::*;

        logic [data_w-1:0] mem [2**mem_addr_w];

        always_ff @(posedge clk_100M or negedge rst_n) begin
                if (!rst_n) begin
                        for (int k = 0; k < 2**mem_addr_w; k++)
                                mem[k] <= '0;
                        rdata <= '0;
                end else if (phase.mem) begin
                        if (we)
                                mem[addr] <= wdata;
                        else if (re)
                                rdata <= mem[addr];
                end
        end

endmodule

// File: cpu_core_top.sv
module cpu_core_top (
        input  logic                clk_100M,
        input  logic                rst_n,
        input  logic                instr_valid,
        output logic                instr_ready,
        input  cpu_pkg::instr_u     instr,
        output logic                wb_valid,
        output cpu_pkg::wb_result_t wb_result
);
        import cpu_pkg::*;

        phase_t                phase;
        instr_u                cur_instr;
        logic                  cur_valid;
        opcode_e               cur_op;
        logic [reg_addr_w-1:0] rs2_sel;
        logic [data_w-1:0]     rs1_data;
        logic [data_w-1:0]     rs2_data;
        logic [data_w-1:0]     alu_y;
        logic                  md_start;
        logic                  md_busy;
        logic                  md_busy_d;
        logic [data_w-1:0]     md_result;
        logic [data_w-1:0]     exec_q;
        logic [data_w-1:0]     ram_rdata;

        assign cur_op = cur_instr.r.opcode;

        // A store reads the register named in rd through the second port.
        assign rs2_sel  = (cur_op == op_st) ? cur_instr.r.rd : cur_instr.r.rs2;
        assign md_start = phase.exec && cur_valid && (cur_op == op_mul || cur_op == op_div);

        phase_gen u_phase (
                .clk_100M (clk_100M),
                .rst_n    (rst_n),
                .md_busy  (md_busy),
                .phase    (phase)
        );

        instr_fetch u_fetch (
                .clk_100M    (clk_100M),
                .rst_n       (rst_n),
                .instr_valid (instr_valid),
                .instr_ready (instr_ready),
                .instr       (instr),
                .phase       (phase),
                .cur_instr   (cur_instr),
                .cur_valid   (cur_valid)
        );

        reg_file u_regs (
                .clk_100M  (clk_100M),
                .rst_n     (rst_n),
                .rs1       (cur_instr.r.rs1),
                .rs2       (rs2_sel),
                .rs1_data  (rs1_data),
                .rs2_data  (rs2_data),
                .we        (wb_valid),
                .wb_result (wb_result)
        );

        alu u_alu (
                .cur_instr (cur_instr),
                .a         (rs1_data),
                .b         (rs2_data),
                .y         (alu_y)
        );

        mul_div_unit u_md (
                .clk_100M  (clk_100M),
                .rst_n     (rst_n),
                .start     (md_start),
                .is_div    (cur_op == op_div),
                .a         (rs1_data),
                .b         (rs2_data),
                .md_busy   (md_busy),
                .md_result (md_result)
        );

        always_ff @(posedge clk_100M or negedge rst_n) begin
                if (!rst_n)
                        md_busy_d <= 1'b0;
                else
                        md_busy_d <= md_busy;
        end

        // The mul/div result replaces the ALU value once busy drops.
        always_ff @(posedge clk_100M) begin
                if (phase.exec && cur_valid)
                        exec_q <= alu_y;
                else if (md_busy_d && !md_busy)
                        exec_q <= md_result;
        end

        data_ram u_ram (
                .clk_100M (clk_100M),
                .rst_n    (rst_n),
                .phase    (phase),
                .we       (cur_valid && cur_op == op_st),
                .re       (cur_valid && cur_op == op_ld),
                .addr     (exec_q[mem_addr_w-1:0]),
                .wdata    (rs2_data),
                .rdata    (ram_rdata)
        );

        assign wb_valid       = phase.wb && cur_valid && (cur_op != op_st);
        assign wb_result.rd   = cur_instr.r.rd;
        assign wb_result.data = (cur_op == op_ld) ? ram_rdata : exec_q;

        // The unit must be done well before the frame reaches the memory slot.
        a_md_length: assert property (
                @(posedge clk_100M) disable iff (!rst_n)
                md_start |=> md_busy [*md_steps] ##1 !md_busy
        );

endmodule

// File: tb_cpu_core.sv
module tb_cpu_core;
        timeunit 1ns;
        timeprecision 1ps;

        import cpu_pkg::*;

        localparam int n_instr       = 200;
        localparam int timeout_limit = n_instr * (frame_last + 1 + md_steps) + 200;
        localparam logic [reg_addr_w-1:0] zero_reg = 3'd6;

        logic                  clk_100M;
        logic                  rst_n;
        logic                  instr_valid;
        logic                  instr_ready;
        instr_u                instr;
        logic                  wb_valid;
        wb_result_t            wb_result;

        logic [data_w-1:0]     model_regs [2**reg_addr_w];
        logic [data_w-1:0]     model_mem [2**mem_addr_w];
        wb_result_t            expected_q [$];
        integer                seed;
        int                    cycle_count = 0;
        logic [reg_addr_w-1:0] st_rs1;
        logic [5:0]            st_imm;

        cpu_core_top UUT (
                .clk_100M    (clk_100M),
                .rst_n       (rst_n),
                .instr_valid (instr_valid),
                .instr_ready (instr_ready),
                .instr       (instr),
                .wb_valid    (wb_valid),
                .wb_result   (wb_result)
        );

        always #5 clk_100M = ~clk_100M;

        task automatic stop_with_failure(input string reason);
                $display("%s", reason);
                $display("TEST FAIL");
                $fatal(1, "simulation stopped on error");
        endtask

        // Expected write-back of one instruction, executed in program order
        // against a shadow register file and memory.
        function automatic wb_result_t model_exec(input instr_u w);
                wb_result_t        res;
                logic [data_w-1:0] a;
                logic [data_w-1:0] b;
                logic [data_w-1:0] addr;
                logic [31:0]       prod;
                int                imm_val;

                a       = model_regs[w.r.rs1];
                b       = model_regs[w.r.rs2];
                imm_val = w.i.imm;
                addr    = a + imm_val[data_w-1:0];
                prod    = {16'b0, a} * {16'b0, b};
                res.rd  = w.r.rd;
                case (w.r.opcode)
                        op_sub:  res.data = a - b;
                        op_and:  res.data = a & b;
                        op_or:   res.data = a | b;
                        op_xor:  res.data = a ^ b;
                        op_addi: res.data = addr;
                        op_mul:  res.data = prod[data_w-1:0];
                        op_div:  res.data = (b == '0) ? '1 : a / b;
                        op_ld:   res.data = model_mem[addr[mem_addr_w-1:0]];
                        op_st: begin
                                res.data = model_regs[w.r.rd];
                                model_mem[addr[mem_addr_w-1:0]] = res.data;
                        end
                        default: res.data = a + b;
                endcase
                if (w.r.opcode != op_st)
                        model_regs[w.r.rd] = res.data;
                return res;
        endfunction

        // Each group of 20 holds a store and a load from the same address,
        // then a cleared register that serves as a zero divisor.
        function automatic instr_u make_instr(input int n);
                instr_u w;
                int     pick;

                w          = '0;
                pick       = {$random(seed)} % 10;
                w.r.opcode = opcode_e'(pick[3:0]);
                w.r.rd     = 3'($random(seed));
                w.r.rs1    = 3'($random(seed));
                w.r.rs2    = 3'($random(seed));
                w.r.pad    = 3'($random(seed));
                case (n % 20)
                        4: begin
                                w.i.opcode = op_st;
                                st_rs1     = w.i.rs1;
                                st_imm     = w.i.imm;
                        end
                        5: begin
                                w.i.opcode = op_ld;
                                w.i.rs1    = st_rs1;
                                w.i.imm    = st_imm;
                        end
                        10: begin
                                w.r.opcode = op_xor;
                                w.r.rd     = zero_reg;
                                w.r.rs1    = zero_reg;
                                w.r.rs2    = zero_reg;
                        end
                        11: begin
                                w.r.opcode = op_div;
                                w.r.rs2    = zero_reg;
                        end
                        default: begin
                                if (w.r.opcode == op_addi && n % 2 == 0)
                                        w.i.imm[5] = 1'b1;
                        end
                endcase
                return w;
        endfunction

        task automatic idle_cycles(input int n);
                instr_valid = 1'b0;
                repeat (n) begin
                        @(posedge clk_100M);
                        #1;
                end
        endtask

        // The transfer is seen at the falling edge before the rising edge that takes it.
        task automatic send_instr(input instr_u w);
                wb_result_t exp;

                instr_valid = 1'b1;
                instr       = w;
                @(negedge clk_100M);
                while (!instr_ready)
                        @(negedge clk_100M);
                if (expected_q.size() > 1) begin
                        stop_with_failure("more than one instruction accepted in one frame");
                end else begin
                        exp = model_exec(w);
                        if (w.r.opcode != op_st)
                                expected_q.push_back(exp);
                        @(posedge clk_100M);
                        #1;
                        instr_valid = 1'b0;
                end
        endtask

        task automatic check_wb(input wb_result_t got);
                wb_result_t exp;

                if (expected_q.size() == 0) begin
                        stop_with_failure($sformatf(
                                "write-back to r%0d appeared with no instruction outstanding",
                                got.rd));
                end else begin
                        exp = expected_q.pop_front();
                        if (got !== exp)
                                stop_with_failure($sformatf(
                                        "FAILED at %0d ns: write-back r%0d = %h, expected r%0d = %h",
                                        $time, got.rd, got.data, exp.rd, exp.data));
                end
        endtask

        always @(negedge clk_100M) begin
                if (rst_n && wb_valid)
                        check_wb(wb_result);
        end

        always @(negedge clk_100M) begin
                cycle_count++;
                if (cycle_count >= timeout_limit)
                        stop_with_failure("timeout: results still outstanding");
        end

        initial begin
                seed        = 32'hf0e3;
                clk_100M    = 1'b0;
                rst_n       = 1'b0;
                instr_valid = 1'b0;
                instr       = '0;
                for (int k = 0; k < 2**reg_addr_w; k++)
                        model_regs[k] = '0;
                for (int k = 0; k < 2**mem_addr_w; k++)
                        model_mem[k] = '0;
                repeat (2) @(posedge clk_100M);
                #1;
                rst_n = 1'b1;

                // The whole first frame runs with nothing sent.
                idle_cycles(frame_last + 10);
                for (int n = 0; n < n_instr; n++) begin
                        send_instr(make_instr(n));
                        if (n % 16 == 15)
                                idle_cycles(30 + {$random(seed)} % 40);
                        else
                                idle_cycles({$random(seed)} % 4);
                end

                while (expected_q.size() != 0)
                        @(negedge clk_100M);
                repeat (2 * (frame_last + 1 + md_steps)) @(negedge clk_100M);

                $display("TEST PASS");
                $finish;
        end

endmodule

// File: src.f
cpu_pkg.sv
phase_gen.sv
instr_fetch.sv
reg_file.sv
alu.sv
mul_div_unit.sv
data_ram.sv
cpu_core_top.sv
tb_cpu_core.sv

// File: Makefile
VERILATOR ?= verilator
TOP       := tb_cpu_core
FILELIST  := src.f
OBJ_DIR   := obj_dir
FLAGS     := --binary --timing --assert -Wno-fatal -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build output"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
